// File: verilog/kdi_defines.svh
////////////////////
// Key derivation widths and counts
// Block, entropy, key, nonce and seed sizes shared by all blocks
////////////////////

`ifndef KDI_DEFINES_SVH
`define KDI_DEFINES_SVH

// Digest engine block width
`define KDI_BLOCK_W 64
// Entropy source word width
`define KDI_EDN_W 32
// Derived key and nonce widths
`define KDI_KEY_W 128
`define KDI_NONCE_W 128

// Seed widths per requester kind
`define KDI_FLASH_SEED_W 256
// Used twice to fill four digest blocks
`define KDI_SRAM_SEED_W 128

// Requesters and block counter width
`define KDI_NUM_REQ 3
`define KDI_CNT_W 2

`endif

// File: verilog/kdi_pkg.sv
////////////////////
// Key derivation types
// Digest commands, constant selects, FSM states and nonce view
////////////////////

`include "kdi_defines.svh"

package kdi_pkg;

  // Commands understood by the digest engine
  typedef enum logic [1:0] {
    LoadShadow     = 2'd0,
    DigestInit     = 2'd1,
    Digest         = 2'd2,
    DigestFinalize = 2'd3
  } scrmbl_cmd_e;

  // Netlist constant index per key kind
  typedef enum logic [1:0] {
    FlashDataKey = 2'd0,
    FlashAddrKey = 2'd1,
    SramDataKey  = 2'd2
  } digest_sel_e;

  // Derivation FSM, plain binary
  typedef enum logic [3:0] {
    Reset        = 4'd0,
    Idle         = 4'd1,
    DigClr       = 4'd2,
    DigLoad      = 4'd3,
    FetchEntropy = 4'd4,
    DigEntropy   = 4'd5,
    DigFin       = 4'd6,
    DigWait      = 4'd7,
    FetchNonce   = 4'd8,
    Finish       = 4'd9,
    Error        = 4'd10
  } state_e;

  // Nonce register, filled per entropy word and read per digest block
  typedef union packed {
    logic [`KDI_NONCE_W/`KDI_EDN_W-1:0][`KDI_EDN_W-1:0]     words;
    logic [`KDI_NONCE_W/`KDI_BLOCK_W-1:0][`KDI_BLOCK_W-1:0] blocks;
  } nonce_u;

endpackage

// File: verilog/kdi_if.sv
////////////////////
// Key derivation internal bundles
// Granted request from arbiter, register control from FSM
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

// Selected request, held by the arbiter until ack
interface kdi_req_if;
  logic                                   valid;
  logic                                   ready;
  logic                                   ingest_entropy;
  logic                                   fetch_nonce;
  // Index of the last nonce word to fetch
  logic [`KDI_CNT_W-1:0]                  nonce_size;
  kdi_pkg::digest_sel_e                   digest_sel;
  logic                                   seed_valid;
  logic [3:0][`KDI_BLOCK_W-1:0]           seed;

  // Arbiter side
  modport arb (
    output valid, ingest_entropy, fetch_nonce, nonce_size, digest_sel,
    output seed_valid, seed,
    input  ready
  );

  // FSM side
  modport ctrl (
    input  valid, ingest_entropy, fetch_nonce, nonce_size, digest_sel,
    output ready
  );

  // Register side
  modport regs (
    input seed, seed_valid, digest_sel
  );
endinterface

// Register enables and mux control, FSM to key registers
interface kdi_reg_if;
  logic                  key_reg_en;
  logic                  nonce_reg_en;
  logic                  seed_valid_reg_en;
  logic                  data_sel_entropy;
  logic [`KDI_CNT_W-1:0] seed_cnt;
  logic [`KDI_CNT_W-1:0] entropy_cnt;

  modport ctrl (
    output key_reg_en, nonce_reg_en, seed_valid_reg_en, data_sel_entropy,
    output seed_cnt, entropy_cnt
  );

  modport regs (
    input key_reg_en, nonce_reg_en, seed_valid_reg_en, data_sel_entropy,
    input seed_cnt, entropy_cnt
  );
endinterface

// File: verilog/kdi_req_arb.sv
////////////////////
// Key request arbiter
// Round-robin pick among requesters, grant held until ack
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

module kdi_req_arb (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flash_data_req_i,
  input  logic                         flash_addr_req_i,
  input  logic                         sram_req_i,
  output logic                         flash_data_ack_o,
  output logic                         flash_addr_ack_o,
  output logic                         sram_ack_o,
  input  logic                         seed_valid_i,
  input  logic [`KDI_FLASH_SEED_W-1:0] flash_data_seed_i,
  input  logic [`KDI_FLASH_SEED_W-1:0] flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0]  sram_seed_i,
  kdi_req_if.arb                       req
);

  logic [`KDI_NUM_REQ-1:0]                        req_vec;
  logic [`KDI_NUM_REQ-1:0]                        ack_vec;
  logic [`KDI_NUM_REQ-1:0][`KDI_FLASH_SEED_W-1:0] seeds;
  logic [`KDI_CNT_W-1:0]                          rr_q;
  logic [`KDI_CNT_W-1:0]                          gnt_idx_q;
  logic [`KDI_CNT_W-1:0]                          pick_idx;
  logic [`KDI_CNT_W-1:0]                          sel_idx;
  logic                                           busy_q;

  assign req_vec = {sram_req_i, flash_addr_req_i, flash_data_req_i};

  // SRAM seed is repeated to cover four blocks
  assign seeds[0] = flash_data_seed_i;
  assign seeds[1] = flash_addr_seed_i;
  assign seeds[2] = {sram_seed_i, sram_seed_i};

  ////////////////////
  // Pick
  ////////////////////

  // First active requester at or after the pointer
  always_comb begin : p_pick
    logic found;
    int   idx;
    found    = 1'b0;
    pick_idx = rr_q;
    for (int i = 0; i < `KDI_NUM_REQ; i++) begin
      idx = (int'(rr_q) + i) % `KDI_NUM_REQ;
      if (!found && req_vec[idx]) begin
        found    = 1'b1;
        pick_idx = idx[`KDI_CNT_W-1:0];
      end
    end
  end

  // Locked index while busy, live pick otherwise
  assign sel_idx   = busy_q ? gnt_idx_q : pick_idx;
  assign req.valid = busy_q | (|req_vec);

  // Per-requester configuration
  always_comb begin : p_cfg
    req.fetch_nonce = 1'b1;
    req.seed_valid  = seed_valid_i;
    req.seed        = seeds[sel_idx];
    case (sel_idx)
      2'd0: begin
        req.ingest_entropy = 1'b0;
        req.digest_sel     = kdi_pkg::FlashDataKey;
        req.nonce_size     = 2'd3;
      end
      2'd1: begin
        req.ingest_entropy = 1'b0;
        req.digest_sel     = kdi_pkg::FlashAddrKey;
        // Two nonce words only
        req.nonce_size     = 2'd1;
      end
      default: begin
        req.ingest_entropy = 1'b1;
        req.digest_sel     = kdi_pkg::SramDataKey;
        req.nonce_size     = 2'd3;
      end
    endcase
  end

  // Ready becomes the granted ack in the same cycle
  always_comb begin : p_ack
    for (int i = 0; i < `KDI_NUM_REQ; i++) begin
      ack_vec[i] = req.ready && (int'(gnt_idx_q) == i);
    end
  end

  assign flash_data_ack_o = ack_vec[0];
  assign flash_addr_ack_o = ack_vec[1];
  assign sram_ack_o       = ack_vec[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      gnt_idx_q <= '0;
      rr_q      <= '0;
    end else if (req.ready) begin
      busy_q <= 1'b0;
      // Pointer moves past the served requester
      rr_q   <= (int'(gnt_idx_q) == `KDI_NUM_REQ - 1) ? '0 : gnt_idx_q + 1'b1;
    end else if (!busy_q && (|req_vec)) begin
      busy_q    <= 1'b1;
      gnt_idx_q <= pick_idx;
    end
  end

endmodule

// File: verilog/kdi_ctrl_fsm.sv
////////////////////
// Key derivation control FSM
// Sequences seed and entropy blocks through the digest engine
// and fetches entropy for ingestion and for the nonce
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

module kdi_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 kdi_en_i,
  input  logic                 escalate_i,
  output logic                 fsm_err_o,
  output logic                 edn_req_o,
  input  logic                 edn_ack_i,
  output kdi_pkg::scrmbl_cmd_e scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e scrmbl_sel_o,
  output logic                 scrmbl_valid_o,
  input  logic                 scrmbl_ready_i,
  input  logic                 scrmbl_valid_i,
  kdi_req_if.ctrl              req,
  kdi_reg_if.ctrl              regs
);

  kdi_pkg::state_e       state_d, state_q;
  logic [`KDI_CNT_W-1:0] seed_cnt_q, entropy_cnt_q;
  logic                  seed_cnt_en, seed_cnt_clr;
  logic                  entropy_cnt_en, entropy_cnt_clr;
  logic                  edn_req_d, edn_req_q;
  logic                  edn_done;

  assign edn_req_o        = edn_req_q;
  // Word accepted only against an open request
  assign edn_done         = edn_req_q & edn_ack_i;
  assign regs.seed_cnt    = seed_cnt_q;
  assign regs.entropy_cnt = entropy_cnt_q;
  assign scrmbl_sel_o     = req.digest_sel;
  assign fsm_err_o        = (state_q == kdi_pkg::Error);

  always_comb begin : p_fsm
    state_d         = state_q;
    seed_cnt_en     = 1'b0;
    seed_cnt_clr    = 1'b0;
    entropy_cnt_en  = 1'b0;
    entropy_cnt_clr = 1'b0;
    // Open request drops the cycle after its ack
    edn_req_d       = edn_req_q & ~edn_ack_i;
    scrmbl_cmd_o    = kdi_pkg::LoadShadow;
    scrmbl_valid_o  = 1'b0;
    req.ready       = 1'b0;
    regs.key_reg_en        = 1'b0;
    regs.nonce_reg_en      = 1'b0;
    regs.seed_valid_reg_en = 1'b0;
    regs.data_sel_entropy  = 1'b0;

    unique case (state_q)
      // Wait for enable after start-up
      kdi_pkg::Reset: begin
        if (kdi_en_i) begin
          state_d = kdi_pkg::Idle;
        end
      end
      kdi_pkg::Idle: begin
        if (req.valid) begin
          state_d         = kdi_pkg::DigClr;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Digest state back to the selected IV
      kdi_pkg::DigClr: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_pkg::DigestInit;
        if (scrmbl_ready_i) begin
          state_d = kdi_pkg::DigLoad;
        end
      end
      // Even block to shadow, odd block triggers a round
      kdi_pkg::DigLoad: begin
        scrmbl_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d = req.ingest_entropy ? kdi_pkg::FetchEntropy : kdi_pkg::DigFin;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Four words into the nonce register
      kdi_pkg::FetchEntropy: begin
        edn_req_d = ~edn_ack_i;
        if (edn_done) begin
          regs.nonce_reg_en = 1'b1;
          if (entropy_cnt_q == 2'd3) begin
            state_d         = kdi_pkg::DigEntropy;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      // Same pairing as the seed, taken from the nonce blocks
      kdi_pkg::DigEntropy: begin
        scrmbl_valid_o        = 1'b1;
        regs.data_sel_entropy = 1'b1;
        if (entropy_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d         = kdi_pkg::DigFin;
            entropy_cnt_clr = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      kdi_pkg::DigFin: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_pkg::DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = kdi_pkg::DigWait;
        end
      end
      // Result goes to key half seed_cnt[1]
      kdi_pkg::DigWait: begin
        if (scrmbl_valid_i) begin
          regs.key_reg_en = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            // Second half starts at block 2
            seed_cnt_en = 1'b1;
            state_d     = kdi_pkg::DigClr;
          end else begin
            seed_cnt_clr           = 1'b1;
            regs.seed_valid_reg_en = 1'b1;
            state_d = req.fetch_nonce ? kdi_pkg::FetchNonce : kdi_pkg::Finish;
          end
        end
      end
      // Overwrite nonce words up to the configured index
      kdi_pkg::FetchNonce: begin
        edn_req_d = ~edn_ack_i;
        if (edn_done) begin
          regs.nonce_reg_en = 1'b1;
          if (entropy_cnt_q == req.nonce_size) begin
            state_d         = kdi_pkg::Finish;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      kdi_pkg::Finish: begin
        req.ready = 1'b1;
        state_d   = kdi_pkg::Idle;
      end
      // Terminal
      kdi_pkg::Error: begin
        state_d = kdi_pkg::Error;
      end
      default: begin
        state_d = kdi_pkg::Error;
      end
    endcase

    // Escalation wins over every state
    if (escalate_i) begin
      state_d = kdi_pkg::Error;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= kdi_pkg::Reset;
      edn_req_q     <= 1'b0;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      if (seed_cnt_clr) begin
        seed_cnt_q <= '0;
      end else if (seed_cnt_en) begin
        seed_cnt_q <= seed_cnt_q + 1'b1;
      end
      if (entropy_cnt_clr) begin
        entropy_cnt_q <= '0;
      end else if (entropy_cnt_en) begin
        entropy_cnt_q <= entropy_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: verilog/kdi_key_regs.sv
////////////////////
// Key, nonce and seed-valid registers
// Also picks the block fed to the digest engine
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

module kdi_key_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`KDI_EDN_W-1:0]   edn_data_i,
  input  logic [`KDI_BLOCK_W-1:0] scrmbl_data_i,
  output logic [`KDI_BLOCK_W-1:0] scrmbl_data_o,
  output logic [`KDI_KEY_W-1:0]   key_o,
  output logic [`KDI_NONCE_W-1:0] nonce_o,
  output logic                    seed_valid_o,
  kdi_req_if.regs                 req,
  kdi_reg_if.regs                 regs
);

  // Key as two digest halves
  logic [`KDI_KEY_W/`KDI_BLOCK_W-1:0][`KDI_BLOCK_W-1:0] key_q;
  kdi_pkg::nonce_u                                      nonce_q;
  logic                                                 seed_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      if (regs.key_reg_en) begin
        key_q[regs.seed_cnt[1]] <= scrmbl_data_i;
      end
      // One entropy word per ack
      if (regs.nonce_reg_en) begin
        nonce_q.words[regs.entropy_cnt] <= edn_data_i;
      end
      if (regs.seed_valid_reg_en) begin
        seed_valid_q <= req.seed_valid;
      end
    end
  end

  // Entropy block, else seed block gated to zero when invalid
  assign scrmbl_data_o = regs.data_sel_entropy ? nonce_q.blocks[regs.entropy_cnt[0]] :
                         req.seed_valid        ? req.seed[regs.seed_cnt]            :
                                                 '0;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

endmodule

// File: verilog/kdi_top.sv
////////////////////
// Scrambling key derivation top
// Arbiter, control FSM and key registers
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

module kdi_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         kdi_en_i,
  input  logic                         escalate_i,
  output logic                         fsm_err_o,
  // Seeds
  input  logic                         seed_valid_i,
  input  logic [`KDI_FLASH_SEED_W-1:0] flash_data_seed_i,
  input  logic [`KDI_FLASH_SEED_W-1:0] flash_addr_seed_i,
  input  logic [`KDI_SRAM_SEED_W-1:0]  sram_seed_i,
  // Requesters
  input  logic                         flash_data_req_i,
  input  logic                         flash_addr_req_i,
  input  logic                         sram_req_i,
  output logic                         flash_data_ack_o,
  output logic                         flash_addr_ack_o,
  output logic                         sram_ack_o,
  output logic [`KDI_KEY_W-1:0]        key_o,
  output logic [`KDI_NONCE_W-1:0]      nonce_o,
  output logic                         seed_valid_o,
  // Entropy source
  output logic                         edn_req_o,
  input  logic                         edn_ack_i,
  input  logic [`KDI_EDN_W-1:0]        edn_data_i,
  // Digest engine
  output kdi_pkg::scrmbl_cmd_e         scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e         scrmbl_sel_o,
  output logic [`KDI_BLOCK_W-1:0]      scrmbl_data_o,
  output logic                         scrmbl_valid_o,
  input  logic                         scrmbl_ready_i,
  input  logic                         scrmbl_valid_i,
  input  logic [`KDI_BLOCK_W-1:0]      scrmbl_data_i
);

  kdi_req_if u_req_if ();
  kdi_reg_if u_reg_if ();

  kdi_req_arb u_req_arb (
    .clk_i,
    .rst_ni,
    .flash_data_req_i,
    .flash_addr_req_i,
    .sram_req_i,
    .flash_data_ack_o,
    .flash_addr_ack_o,
    .sram_ack_o,
    .seed_valid_i,
    .flash_data_seed_i,
    .flash_addr_seed_i,
    .sram_seed_i,
    .req              (u_req_if.arb)
  );

  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .escalate_i,
    .fsm_err_o,
    .edn_req_o,
    .edn_ack_i,
    .scrmbl_cmd_o,
    .scrmbl_sel_o,
    .scrmbl_valid_o,
    .scrmbl_ready_i,
    .scrmbl_valid_i,
    .req            (u_req_if.ctrl),
    .regs           (u_reg_if.ctrl)
  );

  kdi_key_regs u_key_regs (
    .clk_i,
    .rst_ni,
    .edn_data_i,
    .scrmbl_data_i,
    .scrmbl_data_o,
    .key_o,
    .nonce_o,
    .seed_valid_o,
    .req           (u_req_if.regs),
    .regs          (u_reg_if.regs)
  );

endmodule

// File: verification/kdi_sva.sv
////////////////////
// Control FSM assertions
// Entropy handshake, sticky error and quiet digest bus in reset
////////////////////

`timescale 1ns/1ps

module kdi_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic edn_req_o,
  input logic edn_ack_i,
  input logic fsm_err_o,
  input logic scrmbl_valid_o
);

  // Open entropy request waits for its ack
  a_edn_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o)
    else $error("edn_req_o dropped before edn_ack_i");

  // Error state is terminal
  a_err_sticky : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_o |=> fsm_err_o)
    else $error("fsm_err_o fell after being raised");

  // No digest command while reset is applied
  a_rst_quiet : assert property (@(posedge clk_i)
    !rst_ni |-> !scrmbl_valid_o)
    else $error("scrmbl_valid_o high during reset");

endmodule

bind kdi_ctrl_fsm kdi_sva u_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .edn_req_o      (edn_req_o),
  .edn_ack_i      (edn_ack_i),
  .fsm_err_o      (fsm_err_o),
  .scrmbl_valid_o (scrmbl_valid_o)
);

// File: verification/kdi_tb.sv
////////////////////
// Key derivation testbench
// Digest and entropy models, request table, key and nonce checks
////////////////////

`timescale 1ns/1ps

`include "kdi_defines.svh"

module kdi_tb;

  localparam int NUM_ROWS       = 6;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;

  // Per-requester configuration with flash data at index 0 and SRAM at index 2
  localparam kdi_pkg::digest_sel_e CFG_SEL [3] =
    '{kdi_pkg::FlashDataKey, kdi_pkg::FlashAddrKey, kdi_pkg::SramDataKey};
  localparam bit CFG_INGEST [3] = '{1'b0, 1'b0, 1'b1};
  localparam int CFG_NONCE_WORDS [3] = '{4, 2, 4};

  ////////////////////
  // Stimulus table
  ////////////////////

  // Requesters raised (bit 0 flash data), seed valid, seed base, escalate
  localparam logic [2:0] ROW_REQS [NUM_ROWS] =
    '{3'b001, 3'b010, 3'b100, 3'b001, 3'b111, 3'b010};
  localparam bit ROW_SV [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
  localparam logic [63:0] ROW_SEED [NUM_ROWS] =
    '{64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 64'h0f1e_2d3c_4b5a_6978,
      64'h1357_9bdf_2468_ace0, 64'h8899_aabb_ccdd_eeff, 64'h5a5a_a5a5_3c3c_c3c3};
  localparam bit ROW_ESC [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  logic                         clk_i;
  logic                         rst_ni;
  logic                         kdi_en_i;
  logic                         escalate_i;
  logic                         fsm_err_o;
  logic                         seed_valid_i;
  logic [`KDI_FLASH_SEED_W-1:0] flash_data_seed_i;
  logic [`KDI_FLASH_SEED_W-1:0] flash_addr_seed_i;
  logic [`KDI_SRAM_SEED_W-1:0]  sram_seed_i;
  logic                         flash_data_req_i;
  logic                         flash_addr_req_i;
  logic                         sram_req_i;
  logic                         flash_data_ack_o;
  logic                         flash_addr_ack_o;
  logic                         sram_ack_o;
  logic [`KDI_KEY_W-1:0]        key_o;
  logic [`KDI_NONCE_W-1:0]      nonce_o;
  logic                         seed_valid_o;
  logic                         edn_req_o;
  logic                         edn_ack_i;
  logic [`KDI_EDN_W-1:0]        edn_data_i;
  kdi_pkg::scrmbl_cmd_e         scrmbl_cmd_o;
  kdi_pkg::digest_sel_e         scrmbl_sel_o;
  logic [`KDI_BLOCK_W-1:0]      scrmbl_data_o;
  logic                         scrmbl_valid_o;
  logic                         scrmbl_ready_i;
  logic                         scrmbl_valid_i;
  logic [`KDI_BLOCK_W-1:0]      scrmbl_data_i;

  logic [31:0] lfsr_q = 32'ha092;
  logic [31:0] edn_words [$];
  logic [31:0] exp_nonce [4] = '{32'h0, 32'h0, 32'h0, 32'h0};

  kdi_top dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic logic [63:0] rotl1(input logic [63:0] b);
    rotl1 = {b[62:0], b[63]};
  endfunction

  // Distinct block per row, requester and block index
  function automatic logic [63:0] seed_block(input logic [63:0] base, input int req_idx,
                                             input int blk_idx);
    seed_block = base + 64'(req_idx * 4 + blk_idx + 1) * 64'h9e37_79b9_7f4a_7c15;
  endfunction

  // One key half from the IV, one seed pair and an optional entropy pair
  function automatic logic [63:0] digest_half(input logic [1:0] sel,
                                              input logic [63:0] even_blk,
                                              input logic [63:0] odd_blk,
                                              input logic ingest,
                                              input logic [63:0] ent_lo,
                                              input logic [63:0] ent_hi);
    logic [63:0] st;
    st = {8{6'b0, sel}};
    st = st ^ even_blk ^ rotl1(odd_blk);
    if (ingest) begin
      st = st ^ ent_lo ^ rotl1(ent_hi);
    end
    digest_half = st;
  endfunction

  task automatic drive_seeds(input logic [63:0] base);
    flash_data_seed_i = {seed_block(base, 0, 3), seed_block(base, 0, 2),
                         seed_block(base, 0, 1), seed_block(base, 0, 0)};
    flash_addr_seed_i = {seed_block(base, 1, 3), seed_block(base, 1, 2),
                         seed_block(base, 1, 1), seed_block(base, 1, 0)};
    sram_seed_i       = {seed_block(base, 2, 1), seed_block(base, 2, 0)};
  endtask

  // First pending requester at or after the pointer
  function automatic int rr_pick(input logic [2:0] pend, input int ptr);
    int k;
    int idx;
    rr_pick = ptr;
    for (k = 2; k >= 0; k--) begin
      idx = (ptr + k) % 3;
      if (pend[idx]) begin
        rr_pick = idx;
      end
    end
  endfunction

  // Predict key and nonce of the served requester from the words supplied
  task automatic check_result(input int g, input logic sv, input logic [63:0] base);
    logic [63:0] half [2];
    logic [63:0] even_blk;
    logic [63:0] odd_blk;
    logic [63:0] ent_lo;
    logic [63:0] ent_hi;
    int          h;
    int          w;
    int          b;
    check_val("edn word count", 128'(edn_words.size()),
              128'((CFG_INGEST[g] ? 8 : 0) + CFG_NONCE_WORDS[g]));
    for (h = 0; h < 2; h++) begin
      ent_lo = '0;
      ent_hi = '0;
      if (CFG_INGEST[g]) begin
        for (w = 0; w < 4; w++) begin
          exp_nonce[w] = edn_words.pop_front();
        end
        ent_lo = {exp_nonce[1], exp_nonce[0]};
        ent_hi = {exp_nonce[3], exp_nonce[2]};
      end
      // The SRAM seed repeats so both halves start at its block 0
      b        = (g == 2) ? 0 : 2 * h;
      even_blk = sv ? seed_block(base, g, b) : 64'h0;
      odd_blk  = sv ? seed_block(base, g, b + 1) : 64'h0;
      half[h]  = digest_half(CFG_SEL[g], even_blk, odd_blk, CFG_INGEST[g], ent_lo, ent_hi);
    end
    for (w = 0; w < CFG_NONCE_WORDS[g]; w++) begin
      exp_nonce[w] = edn_words.pop_front();
    end
    check_val("key_o", key_o, {half[1], half[0]});
    check_val("nonce_o", nonce_o, {exp_nonce[3], exp_nonce[2], exp_nonce[1], exp_nonce[0]});
    check_val("seed_valid_o", 128'(seed_valid_o), 128'(sv));
  endtask

  ////////////////////
  // Bus models
  ////////////////////

  initial begin : bus_models
    logic                 xfer;
    kdi_pkg::scrmbl_cmd_e cmd;
    logic [1:0]           sel;
    logic [63:0]          blk;
    logic [63:0]          dig_state;
    logic [63:0]          shadow;
    logic [63:0]          result;
    logic [31:0]          r;
    int                   fin_wait;
    int                   edn_wait;
    edn_ack_i      = 1'b0;
    edn_data_i     = '0;
    scrmbl_ready_i = 1'b0;
    scrmbl_valid_i = 1'b0;
    scrmbl_data_i  = '0;
    dig_state      = '0;
    shadow         = '0;
    result         = '0;
    fin_wait       = 0;
    edn_wait       = 0;
    forever begin
      // Digest bus is stable half a cycle before the transfer edge
      @(negedge clk_i);
      xfer = scrmbl_valid_o && scrmbl_ready_i;
      cmd  = scrmbl_cmd_o;
      sel  = scrmbl_sel_o;
      blk  = scrmbl_data_o;
      @(posedge clk_i);
      #1;
      scrmbl_valid_i = 1'b0;
      if (fin_wait > 0) begin
        fin_wait--;
        if (fin_wait == 0) begin
          scrmbl_valid_i = 1'b1;
          scrmbl_data_i  = result;
        end
      end
      if (xfer) begin
        case (cmd)
          kdi_pkg::DigestInit: dig_state = {8{6'b0, sel}};
          kdi_pkg::LoadShadow: shadow = blk;
          kdi_pkg::Digest: dig_state = dig_state ^ shadow ^ rotl1(blk);
          kdi_pkg::DigestFinalize: begin
            // Result seen on the third edge after the finalize
            result   = dig_state;
            fin_wait = 2;
          end
        endcase
      end
      take_bits(1, r);
      scrmbl_ready_i = r[0];
      // Entropy source acks after 1 to 4 cycles
      if (edn_ack_i) begin
        edn_ack_i = 1'b0;
      end else if (edn_req_o) begin
        if (edn_wait == 0) begin
          take_bits(2, r);
          edn_wait = int'(r[1:0]) + 1;
        end
        edn_wait--;
        if (edn_wait == 0) begin
          take_bits(32, r);
          edn_ack_i  = 1'b1;
          edn_data_i = r;
          edn_words.push_back(r);
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic [2:0] pending;
    logic [2:0] acks;
    int         row;
    int         g;
    int         k;
    int         rr_exp;
    rst_ni       = 1'b0;
    kdi_en_i     = 1'b0;
    escalate_i   = 1'b0;
    seed_valid_i = 1'b0;
    flash_data_req_i  = 1'b0;
    flash_addr_req_i  = 1'b0;
    sram_req_i        = 1'b0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i       = '0;
    rr_exp = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Quiet outputs and cleared registers after reset
    check_val("edn_req_o", 128'(edn_req_o), 128'(0));
    check_val("scrmbl_valid_o", 128'(scrmbl_valid_o), 128'(0));
    check_val("ack_o", 128'({sram_ack_o, flash_addr_ack_o, flash_data_ack_o}), 128'(0));
    check_val("fsm_err_o", 128'(fsm_err_o), 128'(0));
    check_val("key_o", key_o, 128'(0));
    check_val("nonce_o", nonce_o, 128'(0));
    @(posedge clk_i);
    #1;
    kdi_en_i = 1'b1;
    @(posedge clk_i);
    #1;
    kdi_en_i = 1'b0;

    for (row = 0; row < NUM_ROWS; row++) begin
      drive_seeds(ROW_SEED[row]);
      seed_valid_i = ROW_SV[row];
      pending      = ROW_REQS[row];
      {sram_req_i, flash_addr_req_i, flash_data_req_i} = pending;
      if (ROW_ESC[row]) begin
        repeat (4) @(posedge clk_i);
        #1;
        check_val("fsm_err_o", 128'(fsm_err_o), 128'(0));
        escalate_i = 1'b1;
        // Error latches and the pending request is never acked
        for (k = 0; k < 40; k++) begin
          @(posedge clk_i);
          #1;
          check_val("fsm_err_o", 128'(fsm_err_o), 128'(1));
          check_val("ack_o", 128'({sram_ack_o, flash_addr_ack_o, flash_data_ack_o}),
                    128'(0));
        end
      end else begin
        while (pending != 3'b000) begin
          @(posedge clk_i);
          #1;
          acks = {sram_ack_o, flash_addr_ack_o, flash_data_ack_o};
          if (acks != 3'b000) begin
            g = rr_pick(pending, rr_exp);
            check_val("ack_o", 128'(acks), 128'(3'b001 << g));
            pending[g] = 1'b0;
            {sram_req_i, flash_addr_req_i, flash_data_req_i} = pending;
            check_result(g, ROW_SV[row], ROW_SEED[row]);
            rr_exp = (g + 1) % 3;
          end
        end
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: kdi_top.f
+incdir+verilog
verilog/kdi_pkg.sv
verilog/kdi_if.sv
verilog/kdi_req_arb.sv
verilog/kdi_ctrl_fsm.sv
verilog/kdi_key_regs.sv
verilog/kdi_top.sv
verification/kdi_sva.sv
verification/kdi_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the key derivation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f kdi_top.f --top-module kdi_tb -o kdi_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out="$(./obj_dir/kdi_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
